// File: Bender.yml
package:
  name: sfu_unit

sources:
  # Design
  - logic/sfu_pkg.sv
  - logic/sfu_dispatch_stage.sv
  - logic/sfu_wctl_unit.sv
  - logic/sfu_csr_unit.sv
  - logic/sfu_rsp_arb.sv
  - logic/sfu_unit.sv

  # Verification
  - target: simulation
    files:
      - dv/sfu_unit_asserts.sv
      - dv/sfu_unit_tb.sv

// File: dv/sfu_unit_asserts.sv
// SFU handshake and reset checks
// Bound into the SFU top level

`timescale 1ns/10ps

module sfu_unit_asserts import sfu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        commit_valid,
    input logic        commit_ready,
    input sfu_commit_t commit,
    input logic        ctl_valid,
    input logic        exe_valid,
    input logic        exe_taken,
    input sfu_req_t    exe_req
);

    // Failed assertions, read by the testbench for its verdict
    int fail_count = 0;

    // Held commit stays put until taken
    commit_stable: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            fail_count++;
            $error("commit changed or dropped while stalled");
        end

    // Dispatched request waits for its unit
    req_held: assert property (@(posedge clk) disable iff (reset)
        exe_valid && !exe_taken |=> exe_valid && $stable(exe_req))
        else begin
            fail_count++;
            $error("dispatched request dropped or changed while stalled");
        end

    reset_quiet: assert property (@(posedge clk)
        reset |=> !commit_valid && !ctl_valid)
        else begin
            fail_count++;
            $error("commit_valid or ctl_valid high after reset");
        end

endmodule

bind sfu_unit sfu_unit_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit),
    .ctl_valid    (ctl_valid),
    .exe_valid    (wctl_valid || csr_valid),
    .exe_taken    ((wctl_valid && wctl_ready) || (csr_valid && csr_ready)),
    .exe_req      (exe_req)
);

// File: dv/sfu_unit_tb.sv
// SFU testbench
// Random TMC, WSPAWN and CSR traffic under commit back-pressure, checked
// against a reference model of the warp-control and CSR rules

`timescale 1ns/10ps

module sfu_unit_tb import sfu_pkg::*; ();

    localparam int CORE_ID        = 5;
    localparam int NUM_SCRATCH    = 4;
    localparam int NUM_INSTR      = 300;
    localparam int RESET_CYCLES   = 5;
    localparam int CLK_PERIOD     = 8;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20 + RESET_CYCLES;
    localparam int NUM_UUIDS      = 2 ** UUID_BITS;

    logic        clk;
    logic        reset;
    logic        req_valid;
    sfu_req_t    req;
    logic        req_ready;
    logic        commit_valid;
    sfu_commit_t commit;
    logic        commit_ready;
    logic        ctl_valid;
    warp_ctl_t   ctl;

    integer          seed = 11470;
    logic [XLEN-1:0] ref_scratch [NUM_SCRATCH];
    sfu_commit_t     exp_tab [NUM_UUIDS];
    logic            pending [NUM_UUIDS];
    warp_ctl_t       ctl_q [$];
    warp_ctl_t       exp_ctl;
    int              issued;
    int              committed;
    int              mismatches;
    int              other_errs;
    logic            taken;

    sfu_unit #(
        .CORE_ID     (CORE_ID),
        .NUM_SCRATCH (NUM_SCRATCH)
    ) u_sfu_unit (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int lowest_active(input logic [NUM_LANES-1:0] mask);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic sfu_req_t random_request(input logic [UUID_BITS-1:0] uuid);
        sfu_req_t r;
        int       sel;
        r       = '0;
        r.uuid  = uuid;
        r.wid   = WID_BITS'($random(seed));
        r.tmask = NUM_LANES'($random(seed));
        if (r.tmask == '0) begin
            r.tmask[NUM_LANES-1] = 1'b1;
        end
        r.op = sfu_op_e'(3'($unsigned($random(seed)) % 5));
        r.pc = $random(seed) & 32'hFFFF_FFFC;
        r.rd = 5'($random(seed));
        r.wb = 1'($random(seed));
        for (int i = 0; i < NUM_LANES; i++) begin
            r.rs1_data[i] = $random(seed);
            r.rs2_data[i] = $random(seed);
            // Small warp counts so spawn masks vary
            if (r.op == OP_WSPAWN) begin
                r.rs1_data[i] = $unsigned($random(seed)) % 6;
            end
        end
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            4:       r.csr_addr = CSR_WARP_ID;
            5:       r.csr_addr = CSR_THREAD_ID;
            6:       r.csr_addr = CSR_CORE_ID;
            7:       r.csr_addr = ($random(seed) & 1) ? 12'h004 : 12'h7C0;
            default: r.csr_addr = CSR_ADDR_BITS'(sel);
        endcase
        return r;
    endfunction

    // Reference model, applied in issue order
    function automatic sfu_commit_t expected_commit(input sfu_req_t r);
        sfu_commit_t     c;
        logic [XLEN-1:0] old_v;
        logic [XLEN-1:0] opnd;
        c       = '0;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        if (r.op == OP_TMC || r.op == OP_WSPAWN) begin
            return c;
        end
        c.wb = r.wb;
        opnd = r.rs1_data[lowest_active(r.tmask)];
        if (r.csr_addr < NUM_SCRATCH) begin
            old_v = ref_scratch[r.csr_addr];
        end else if (r.csr_addr == CSR_WARP_ID) begin
            old_v = XLEN'(r.wid);
        end else if (r.csr_addr == CSR_CORE_ID) begin
            old_v = CORE_ID;
        end else begin
            old_v = '0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            c.data[i] = (r.csr_addr == CSR_THREAD_ID) ? XLEN'(i) : old_v;
        end
        if (r.csr_addr < NUM_SCRATCH) begin
            case (r.op)
                OP_CSRRW: ref_scratch[r.csr_addr] = opnd;
                OP_CSRRS: ref_scratch[r.csr_addr] = old_v | opnd;
                default:  ref_scratch[r.csr_addr] = old_v & ~opnd;
            endcase
        end
        return c;
    endfunction

    function automatic warp_ctl_t expected_ctl(input sfu_req_t r);
        warp_ctl_t       e;
        logic [XLEN-1:0] arg;
        int              n;
        e     = '0;
        e.wid = r.wid;
        e.op  = r.op;
        arg   = r.rs1_data[lowest_active(r.tmask)];
        if (r.op == OP_TMC) begin
            e.tmc_mask = arg[NUM_LANES-1:0];
        end else begin
            n            = (arg >= NUM_WARPS) ? NUM_WARPS : int'(arg);
            e.spawn_mask = NUM_WARPS'((32'd1 << n) - 1);
            e.spawn_pc   = r.rs2_data[lowest_active(r.tmask)];
        end
        return e;
    endfunction

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (req_ready && !commit_valid && !ctl_valid) else begin
                mismatches++;
                $display("mismatch at %0t: idle DUT req_ready %b commit_valid %b ctl_valid %b",
                         $time, req_ready, commit_valid, ctl_valid);
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b0;
        issued       = 0;
        committed    = 0;
        mismatches   = 0;
        other_errs   = 0;
        taken        = 1'b0;
        for (int i = 0; i < NUM_SCRATCH; i++) begin
            ref_scratch[i] = '0;
        end
        for (int i = 0; i < NUM_UUIDS; i++) begin
            pending[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_idle(4);

        while (issued < NUM_INSTR || committed < issued) begin
            @(posedge clk);
            if (req_valid && req_ready) begin
                exp_tab[req.uuid] = expected_commit(req);
                pending[req.uuid] = 1'b1;
                if (req.op == OP_TMC || req.op == OP_WSPAWN) begin
                    ctl_q.push_back(expected_ctl(req));
                end
                issued++;
                taken = 1'b1;
            end
            @(negedge clk);
            commit_ready = ($random(seed) & 3) != 0;
            if (taken) begin
                req_valid = 1'b0;
                taken     = 1'b0;
            end
            if (!req_valid && issued < NUM_INSTR && ($random(seed) & 3) != 0) begin
                req       = random_request(UUID_BITS'(issued));
                req_valid = 1'b1;
            end
        end

        commit_ready = 1'b1;
        repeat (6) @(negedge clk);
        for (int i = 0; i < NUM_UUIDS; i++) begin
            assert (!pending[i]) else begin
                other_errs++;
                $display("Instruction with uuid %0d never committed", i);
            end
        end
        assert (ctl_q.size() == 0) else begin
            other_errs++;
            $display("%0d expected warp-control events never appeared", ctl_q.size());
        end

        $display("Checked %0d commits: %0d mismatches, %0d other errors, %0d assertion failures",
                 committed, mismatches, other_errs, u_sfu_unit.u_asserts.fail_count);
        if (mismatches == 0 && other_errs == 0 && u_sfu_unit.u_asserts.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Scoreboard
    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            committed++;
            assert (pending[commit.uuid]) else begin
                other_errs++;
                $display("Commit for uuid %0d arrived with no outstanding instruction",
                         commit.uuid);
            end
            if (pending[commit.uuid]) begin
                assert (commit === exp_tab[commit.uuid]) else begin
                    mismatches++;
                    $display("mismatch at %0t: uuid %0d commit %h expected %h", $time,
                             commit.uuid, commit, exp_tab[commit.uuid]);
                end
                pending[commit.uuid] = 1'b0;
            end
        end
        if (!reset && ctl_valid) begin
            assert (ctl_q.size() > 0) else begin
                other_errs++;
                $display("Warp-control event at %0t with none expected", $time);
            end
            if (ctl_q.size() > 0) begin
                exp_ctl = ctl_q.pop_front();
                assert (ctl === exp_ctl) else begin
                    mismatches++;
                    $display("mismatch at %0t: ctl event %h expected %h", $time, ctl, exp_ctl);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with %0d of %0d instructions committed",
                 TIMEOUT_CYCLES, committed, NUM_INSTR);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: logic/sfu_csr_unit.sv
// SFU CSR unit
// CSRRW/CSRRS/CSRRC on scratch registers plus read-only warp, thread
// and core identity registers

`timescale 1ns/10ps

module sfu_csr_unit import sfu_pkg::*; #(
    parameter int CORE_ID     = 0,
    parameter int NUM_SCRATCH = 4
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        exe_valid,
    input  sfu_req_t    exe_req,
    output logic        exe_ready,

    output logic        rsp_valid,
    output sfu_commit_t rsp,
    input  logic        rsp_ready
);

    localparam int SCR_BITS = (NUM_SCRATCH > 1) ? $clog2(NUM_SCRATCH) : 1;

    logic [XLEN-1:0]                scratch [NUM_SCRATCH];
    logic [SCR_BITS-1:0]            scr_idx;
    logic                           is_scratch;
    logic                           accept;
    logic [XLEN-1:0]                operand;
    logic [XLEN-1:0]                old_val;
    logic [XLEN-1:0]                new_val;
    logic [NUM_LANES-1:0][XLEN-1:0] lane_data;

    assign exe_ready = !rsp_valid || rsp_ready;
    assign accept    = exe_valid && exe_ready;

    assign is_scratch = exe_req.csr_addr < CSR_ADDR_BITS'(NUM_SCRATCH);
    assign scr_idx    = exe_req.csr_addr[SCR_BITS-1:0];
    assign operand    = exe_req.rs1_data[lowest_lane(exe_req.tmask)];

    always_comb begin
        old_val = '0;
        if (is_scratch) begin
            old_val = scratch[scr_idx];
        end else begin
            case (exe_req.csr_addr)
                CSR_WARP_ID: old_val = XLEN'(exe_req.wid);
                CSR_CORE_ID: old_val = XLEN'(CORE_ID);
                default:     old_val = '0;
            endcase
        end
    end

    always_comb begin
        case (exe_req.op)
            OP_CSRRW: new_val = operand;
            OP_CSRRS: new_val = old_val | operand;
            OP_CSRRC: new_val = old_val & ~operand;
            default:  new_val = old_val;
        endcase
    end

    // Thread id is the only per-lane value
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_data[i] = (exe_req.csr_addr == CSR_THREAD_ID) ? XLEN'(i) : old_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else if (accept && is_scratch) begin
            scratch[scr_idx] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.uuid  <= exe_req.uuid;
            rsp.wid   <= exe_req.wid;
            rsp.tmask <= exe_req.tmask;
            rsp.pc    <= exe_req.pc;
            rsp.rd    <= exe_req.rd;
            rsp.wb    <= exe_req.wb;
            rsp.data  <= lane_data;
        end
    end

endmodule

// File: logic/sfu_dispatch_stage.sv
// SFU dispatch stage
// One-entry register for issued instructions, routed to the warp-control
// or CSR unit by opcode

`timescale 1ns/10ps

module sfu_dispatch_stage import sfu_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     req_valid,
    input  sfu_req_t req,
    output logic     req_ready,

    output logic     wctl_valid,
    input  logic     wctl_ready,
    output logic     csr_valid,
    input  logic     csr_ready,
    output sfu_req_t exe_req
);

    logic     full;
    sfu_req_t entry;
    logic     is_wctl;
    logic     sel_ready;

    assign is_wctl = (entry.op == OP_TMC) || (entry.op == OP_WSPAWN);

    assign wctl_valid = full && is_wctl;
    assign csr_valid  = full && !is_wctl;
    assign exe_req    = entry;

    // Ready follows whichever unit the held entry targets
    assign sel_ready = is_wctl ? wctl_ready : csr_ready;
    assign req_ready = !full || sel_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (req_valid && req_ready) begin
            full <= 1'b1;
        end else if (sel_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            entry <= req;
        end
    end

endmodule

// File: logic/sfu_pkg.sv
// SFU shared definitions
// Data widths, opcodes, request/commit/warp-control records and the CSR map

package sfu_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_LANES = 4;
    localparam int WID_BITS  = 2;
    localparam int UUID_BITS = 8;

    localparam int NUM_WARPS     = 2 ** WID_BITS;
    localparam int LANE_BITS     = $clog2(NUM_LANES);
    localparam int CSR_ADDR_BITS = 12;

    // Read-only identity registers
    localparam logic [CSR_ADDR_BITS-1:0] CSR_WARP_ID   = 12'hCC0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_THREAD_ID = 12'hCC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CORE_ID   = 12'hCC2;

    typedef enum logic [2:0] {
        OP_TMC,
        OP_WSPAWN,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC
    } sfu_op_e;

    typedef struct packed {
        logic [UUID_BITS-1:0]                uuid;
        logic [WID_BITS-1:0]                 wid;
        logic [NUM_LANES-1:0]                tmask;
        sfu_op_e                             op;
        logic [XLEN-1:0]                     pc;
        logic [4:0]                          rd;
        logic                                wb;
        logic [CSR_ADDR_BITS-1:0]            csr_addr;
        logic [NUM_LANES-1:0][XLEN-1:0]      rs1_data;
        logic [NUM_LANES-1:0][XLEN-1:0]      rs2_data;
    } sfu_req_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]                uuid;
        logic [WID_BITS-1:0]                 wid;
        logic [NUM_LANES-1:0]                tmask;
        logic [XLEN-1:0]                     pc;
        logic [4:0]                          rd;
        logic                                wb;
        logic [NUM_LANES-1:0][XLEN-1:0]      data;
    } sfu_commit_t;

    typedef struct packed {
        logic [WID_BITS-1:0]                 wid;
        sfu_op_e                             op;
        logic [NUM_LANES-1:0]                tmc_mask;
        logic [NUM_WARPS-1:0]                spawn_mask;
        logic [XLEN-1:0]                     spawn_pc;
    } warp_ctl_t;

    // Index of the lowest set bit, 0 when the mask is empty
    function automatic logic [LANE_BITS-1:0] lowest_lane(input logic [NUM_LANES-1:0] mask);
        logic [LANE_BITS-1:0] idx;
        idx = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = LANE_BITS'(i);
            end
        end
        return idx;
    endfunction

endpackage

// File: logic/sfu_rsp_arb.sv
// SFU response arbiter
// Round-robin merge of the two unit results into one registered commit

`timescale 1ns/10ps

module sfu_rsp_arb import sfu_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    input  logic [1:0]        in_valid,
    input  sfu_commit_t [1:0] in_rsp,
    output logic [1:0]        in_ready,

    output logic              commit_valid,
    output sfu_commit_t       commit,
    input  logic              commit_ready
);

    logic last;
    logic sel;
    logic load;
    logic any_valid;

    assign any_valid = |in_valid;
    assign load      = !commit_valid || commit_ready;

    // On contention the input not granted last wins
    always_comb begin
        case (in_valid)
            2'b11:   sel = ~last;
            2'b10:   sel = 1'b1;
            default: sel = 1'b0;
        endcase
    end

    assign in_ready[0] = load && !sel;
    assign in_ready[1] = load && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            // Warp control goes first after reset
            last         <= 1'b1;
        end else if (load) begin
            commit_valid <= any_valid;
            if (any_valid) begin
                last <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && any_valid) begin
            commit <= in_rsp[sel];
        end
    end

endmodule

// File: logic/sfu_unit.sv
// SFU top level
// Dispatch stage, warp-control and CSR units, and the commit arbiter

`timescale 1ns/10ps

module sfu_unit import sfu_pkg::*; #(
    parameter int CORE_ID     = 0,
    parameter int NUM_SCRATCH = 4
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        req_valid,
    input  sfu_req_t    req,
    output logic        req_ready,

    output logic        commit_valid,
    output sfu_commit_t commit,
    input  logic        commit_ready,

    output logic        ctl_valid,
    output warp_ctl_t   ctl
);

    logic              wctl_valid;
    logic              wctl_ready;
    logic              csr_valid;
    logic              csr_ready;
    sfu_req_t          exe_req;

    // Arbiter input 0 is warp control, input 1 is CSR
    logic [1:0]        rsp_valid;
    logic [1:0]        rsp_ready;
    sfu_commit_t [1:0] rsp;

    sfu_dispatch_stage u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .wctl_valid (wctl_valid),
        .wctl_ready (wctl_ready),
        .csr_valid  (csr_valid),
        .csr_ready  (csr_ready),
        .exe_req    (exe_req)
    );

    sfu_wctl_unit u_wctl (
        .clk        (clk),
        .reset      (reset),
        .exe_valid  (wctl_valid),
        .exe_req    (exe_req),
        .exe_ready  (wctl_ready),
        .ctl_valid  (ctl_valid),
        .ctl        (ctl),
        .rsp_valid  (rsp_valid[0]),
        .rsp        (rsp[0]),
        .rsp_ready  (rsp_ready[0])
    );

    sfu_csr_unit #(
        .CORE_ID     (CORE_ID),
        .NUM_SCRATCH (NUM_SCRATCH)
    ) u_csr (
        .clk        (clk),
        .reset      (reset),
        .exe_valid  (csr_valid),
        .exe_req    (exe_req),
        .exe_ready  (csr_ready),
        .rsp_valid  (rsp_valid[1]),
        .rsp        (rsp[1]),
        .rsp_ready  (rsp_ready[1])
    );

    sfu_rsp_arb u_rsp_arb (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (rsp_valid),
        .in_rsp       (rsp),
        .in_ready     (rsp_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// File: logic/sfu_wctl_unit.sv
// SFU warp-control unit
// Executes TMC and WSPAWN, raises a one-cycle event to the scheduler and
// retires each instruction with an empty commit record

`timescale 1ns/10ps

module sfu_wctl_unit import sfu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        exe_valid,
    input  sfu_req_t    exe_req,
    output logic        exe_ready,

    output logic        ctl_valid,
    output warp_ctl_t   ctl,

    output logic        rsp_valid,
    output sfu_commit_t rsp,
    input  logic        rsp_ready
);

    logic [LANE_BITS-1:0] lane;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      op_b;
    logic                 accept;
    warp_ctl_t            ctl_next;

    assign exe_ready = !rsp_valid || rsp_ready;
    assign accept    = exe_valid && exe_ready;

    // Operands come from the lowest active thread
    assign lane = lowest_lane(exe_req.tmask);
    assign op_a = exe_req.rs1_data[lane];
    assign op_b = exe_req.rs2_data[lane];

    always_comb begin
        ctl_next     = '0;
        ctl_next.wid = exe_req.wid;
        ctl_next.op  = exe_req.op;
        if (exe_req.op == OP_TMC) begin
            ctl_next.tmc_mask = op_a[NUM_LANES-1:0];
        end else if (exe_req.op == OP_WSPAWN) begin
            // Low warps up to the requested count
            for (int w = 0; w < NUM_WARPS; w++) begin
                ctl_next.spawn_mask[w] = op_a > XLEN'(w);
            end
            ctl_next.spawn_pc = op_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            ctl_valid <= accept;
            if (accept) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl       <= ctl_next;
            rsp.uuid  <= exe_req.uuid;
            rsp.wid   <= exe_req.wid;
            rsp.tmask <= exe_req.tmask;
            rsp.pc    <= exe_req.pc;
            rsp.rd    <= exe_req.rd;
            rsp.wb    <= 1'b0;
            rsp.data  <= '0;
        end
    end

endmodule

// File: project.f
logic/sfu_pkg.sv
logic/sfu_dispatch_stage.sv
logic/sfu_wctl_unit.sv
logic/sfu_csr_unit.sv
logic/sfu_rsp_arb.sv
logic/sfu_unit.sv
dv/sfu_unit_asserts.sv
dv/sfu_unit_tb.sv
